//--- source/icache_pkg.sv
/*
 * Cache geometry and the basic address and data types.
 * Imported by every RTL module of the instruction cache.
 */
package icache_pkg;

    // **************************************************
    // geometry
    // **************************************************
    localparam int WAYS        = 2;
    localparam int SETS        = 256;
    localparam int LINE_WORDS  = 4;
    localparam int WORD_BITS   = 32;
    localparam int TAG_BITS    = 20;
    localparam int INDEX_BITS  = 8;
    localparam int OFFSET_BITS = 4;

    // **************************************************
    // types
    // **************************************************
    typedef logic [TAG_BITS+INDEX_BITS+OFFSET_BITS-1:0] addr_t;
    typedef logic [TAG_BITS-1:0]                        tag_t;
    typedef logic [INDEX_BITS-1:0]                      index_t;
    typedef logic [WORD_BITS-1:0]                       word_t;

    // word 0 sits in the low bits
    typedef logic [LINE_WORDS*WORD_BITS-1:0]            line_t;

    // hit, valid and victim vectors
    typedef logic [WAYS-1:0]                            way_vec_t;

endpackage

//--- source/icache_bus_pkg.sv
/*
 * Request structs for the CPU ports and the command that the
 * controller sends to both ways.
 */
package icache_bus_pkg;

    import icache_pkg::*;

    // instruction fetch request
    typedef struct packed {
        addr_t addr;
        logic  uncached;
    } fetch_req_t;

    // index invalidate of one set and one way
    typedef struct packed {
        index_t index;
        logic   way;
    } inval_req_t;

    // **************************************************
    // array command shared by all ways
    // **************************************************
    typedef struct packed {
        logic     read;
        index_t   index;
        // compare tag in lookup and written tag on a fill
        tag_t     tag;
        way_vec_t fill;
        way_vec_t inval;
    } array_cmd_t;

endpackage

//--- source/sync_ram.sv
/*
 * Single-port synchronous RAM. The entry type is a parameter, so one
 * module holds both tag and line payloads. Read data shows up one
 * cycle after an enabled read.
 */
module sync_ram import icache_pkg::*; #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 256
) (
    input  logic   clock,
    input  logic   enable_i,
    input  logic   write_i,
    input  index_t addr_i,
    input  entry_t wdata_i,
    output entry_t rdata_o
);

    entry_t mem [DEPTH];

    always_ff @(posedge clock) begin
        if (enable_i) begin
            if (write_i) begin
                mem[addr_i] <= wdata_i;
            end
            // read-first on a write cycle
            rdata_o <= mem[addr_i];
        end
    end

endmodule

//--- source/cache_way.sv
/*
 * One cache way: tag RAM, data RAM, per-set valid flops and the
 * hit compare. Driven by the array command from the controller.
 */
module cache_way import icache_pkg::*, icache_bus_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  array_cmd_t cmd_i,
    input  logic       way_sel_fill_i,
    input  logic       way_sel_inval_i,
    input  line_t      fill_line_i,
    output logic       hit_o,
    output logic       valid_o,
    output line_t      line_o
);

    logic [SETS-1:0] valid_q;
    logic            valid_rd_q;
    tag_t            tag_rd;
    logic            ram_enable;

    assign ram_enable = cmd_i.read | way_sel_fill_i;

    sync_ram #(.entry_t(tag_t), .DEPTH(SETS)) u_tag_ram (
        .clock    (clock),
        .enable_i (ram_enable),
        .write_i  (way_sel_fill_i),
        .addr_i   (cmd_i.index),
        .wdata_i  (cmd_i.tag),
        .rdata_o  (tag_rd)
    );

    sync_ram #(.entry_t(line_t), .DEPTH(SETS)) u_data_ram (
        .clock    (clock),
        .enable_i (ram_enable),
        .write_i  (way_sel_fill_i),
        .addr_i   (cmd_i.index),
        .wdata_i  (fill_line_i),
        .rdata_o  (line_o)
    );

    // valid bits in flops so the cache comes up empty
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q    <= '0;
            valid_rd_q <= 1'b0;
        end else begin
            if (cmd_i.read) begin
                valid_rd_q <= valid_q[cmd_i.index];
            end
            if (way_sel_fill_i) begin
                valid_q[cmd_i.index] <= 1'b1;
            end else if (way_sel_inval_i) begin
                valid_q[cmd_i.index] <= 1'b0;
            end
        end
    end

    assign valid_o = valid_rd_q;
    assign hit_o   = valid_rd_q && (tag_rd == cmd_i.tag);

endmodule

//--- source/lru_table.sv
/*
 * LRU state for a two-way cache, one bit per set naming the way to
 * replace next. The victim is latched in the lookup cycle and held
 * for the refill.
 */
module lru_table import icache_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  index_t   index_i,
    input  logic     lookup_i,
    input  way_vec_t way_valid_i,
    input  way_vec_t way_hit_i,
    input  logic     fill_i,
    output way_vec_t victim_o
);

    logic [SETS-1:0] lru_q;
    way_vec_t        victim_q;
    way_vec_t        pick;

    // an invalid way goes first
    always_comb begin
        if (!way_valid_i[0]) begin
            pick = 2'b01;
        end else if (!way_valid_i[1]) begin
            pick = 2'b10;
        end else if (lru_q[index_i]) begin
            pick = 2'b10;
        end else begin
            pick = 2'b01;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            lru_q    <= '0;
            victim_q <= '0;
        end else begin
            if (lookup_i) begin
                victim_q <= pick;
                // hit in way 0 makes way 1 the next victim
                if (|way_hit_i) begin
                    lru_q[index_i] <= way_hit_i[0];
                end
            end
            if (fill_i) begin
                lru_q[index_i] <= victim_q[0];
            end
        end
    end

    assign victim_o = victim_q;

endmodule

//--- source/refill_collector.sv
/*
 * Collects the four return beats of a line refill. The first three
 * beats are stored, the fourth passes straight through so the line
 * is complete in the cycle of the last beat.
 */
module refill_collector import icache_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  start_i,
    input  logic  beat_valid_i,
    input  word_t beat_data_i,
    output logic  last_o,
    output line_t line_o
);

    logic [1:0] beat_cnt_q;
    word_t      words_q [LINE_WORDS-1];

    always_ff @(posedge clock) begin
        if (reset || start_i) begin
            beat_cnt_q <= 2'd0;
        end else if (beat_valid_i) begin
            beat_cnt_q <= beat_cnt_q + 2'd1;
        end
    end

    // beats 0 to 2
    always_ff @(posedge clock) begin
        if (beat_valid_i && beat_cnt_q != 2'd3) begin
            words_q[beat_cnt_q] <= beat_data_i;
        end
    end

    assign last_o = beat_valid_i && (beat_cnt_q == 2'd3);
    assign line_o = {beat_data_i, words_q[2], words_q[1], words_q[0]};

endmodule

//--- source/icache_ctrl.sv
/*
 * Cache controller. Accepts fetch and invalidate requests in idle,
 * runs the lookup, issues the line request on a miss and returns the
 * line from the hit way or from the refill.
 */
module icache_ctrl import icache_pkg::*, icache_bus_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       fetch_valid_i,
    input  fetch_req_t fetch_req_i,
    input  logic       inval_valid_i,
    input  inval_req_t inval_req_i,
    output logic       req_ready_o,
    output logic       resp_valid_o,
    output line_t      resp_line_o,
    output logic       mem_req_valid_o,
    output addr_t      mem_addr_o,
    input  logic       mem_req_ready_i,
    output array_cmd_t cmd_o,
    input  way_vec_t   way_hit_i,
    input  line_t      way_line_i [WAYS],
    input  way_vec_t   victim_i,
    output logic       lookup_o,
    output logic       refill_start_o,
    input  logic       refill_last_i,
    input  line_t      refill_line_i
);

    typedef enum logic [1:0] {
        state_idle,
        state_lookup,
        state_request,
        state_receive
    } state_t;

    state_t state;
    tag_t   req_tag_q;
    index_t req_index_q;
    logic   req_uncached_q;
    logic   state_is_idle;
    logic   inval_go;
    logic   fetch_go;
    logic   hit_resp;
    logic   refill_resp;
    line_t  hit_line;

    assign state_is_idle = (state == state_idle);
    // invalidate wins and the fetch stays pending
    assign inval_go = state_is_idle && inval_valid_i;
    assign fetch_go = state_is_idle && fetch_valid_i && !inval_valid_i;

    // **************************************************
    // state machine and request buffer
    // **************************************************
    always_ff @(posedge clock) begin
        if (reset) begin
            state          <= state_idle;
            req_uncached_q <= 1'b0;
        end else begin
            case (state)
                state_idle: begin
                    if (fetch_go) begin
                        state          <= fetch_req_i.uncached ? state_request : state_lookup;
                        req_uncached_q <= fetch_req_i.uncached;
                    end
                end
                state_lookup: begin
                    state <= (|way_hit_i) ? state_idle : state_request;
                end
                state_request: begin
                    if (mem_req_ready_i) begin
                        state <= state_receive;
                    end
                end
                state_receive: begin
                    if (refill_last_i) begin
                        state <= state_idle;
                    end
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_go) begin
            req_tag_q   <= fetch_req_i.addr[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
            req_index_q <= fetch_req_i.addr[OFFSET_BITS +: INDEX_BITS];
        end
    end

    // **************************************************
    // array command
    // **************************************************
    always_comb begin
        cmd_o.read = fetch_go && !fetch_req_i.uncached;
        if (!state_is_idle) begin
            cmd_o.index = req_index_q;
        end else if (inval_valid_i) begin
            cmd_o.index = inval_req_i.index;
        end else begin
            cmd_o.index = fetch_req_i.addr[OFFSET_BITS +: INDEX_BITS];
        end
        cmd_o.tag   = req_tag_q;
        cmd_o.fill  = (state == state_receive && refill_last_i && !req_uncached_q) ?
                      victim_i : '0;
        cmd_o.inval = inval_go ? (way_vec_t'(1) << inval_req_i.way) : '0;
    end

    // **************************************************
    // response and memory request
    // **************************************************
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (way_hit_i[w]) begin
                hit_line = hit_line | way_line_i[w];
            end
        end
    end

    assign hit_resp    = (state == state_lookup) && (|way_hit_i);
    assign refill_resp = (state == state_receive) && refill_last_i;

    assign req_ready_o     = state_is_idle;
    assign resp_valid_o    = hit_resp || refill_resp;
    assign resp_line_o     = hit_resp ? hit_line : refill_line_i;
    assign mem_req_valid_o = (state == state_request);
    assign mem_addr_o      = {req_tag_q, req_index_q, {OFFSET_BITS{1'b0}}};
    assign refill_start_o  = mem_req_valid_o && mem_req_ready_i;
    assign lookup_o        = (state == state_lookup);

endmodule

//--- source/icache_top.sv
/*
 * Two-way set-associative instruction cache, top level.
 * Connects the controller, the two ways, the LRU table and the
 * refill collector.
 */
module icache_top import icache_pkg::*, icache_bus_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       fetch_valid_i,
    input  fetch_req_t fetch_req_i,
    input  logic       inval_valid_i,
    input  inval_req_t inval_req_i,
    output logic       req_ready_o,
    output logic       resp_valid_o,
    output line_t      resp_line_o,
    output logic       mem_req_valid_o,
    output addr_t      mem_addr_o,
    input  logic       mem_req_ready_i,
    input  logic       mem_ret_valid_i,
    input  word_t      mem_ret_data_i
);

    array_cmd_t array_cmd;
    way_vec_t   way_hit;
    way_vec_t   way_valid;
    line_t      way_line [WAYS];
    way_vec_t   victim;
    logic       lookup;
    logic       refill_start;
    logic       refill_last;
    line_t      refill_line;

    icache_ctrl u_ctrl (
        .clock           (clock),
        .reset           (reset),
        .fetch_valid_i   (fetch_valid_i),
        .fetch_req_i     (fetch_req_i),
        .inval_valid_i   (inval_valid_i),
        .inval_req_i     (inval_req_i),
        .req_ready_o     (req_ready_o),
        .resp_valid_o    (resp_valid_o),
        .resp_line_o     (resp_line_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_addr_o      (mem_addr_o),
        .mem_req_ready_i (mem_req_ready_i),
        .cmd_o           (array_cmd),
        .way_hit_i       (way_hit),
        .way_line_i      (way_line),
        .victim_i        (victim),
        .lookup_o        (lookup),
        .refill_start_o  (refill_start),
        .refill_last_i   (refill_last),
        .refill_line_i   (refill_line)
    );

    // per-way select bits out of the shared command
    for (genvar i = 0; i < WAYS; i++) begin : u_way
        cache_way u_cache_way (
            .clock           (clock),
            .reset           (reset),
            .cmd_i           (array_cmd),
            .way_sel_fill_i  (array_cmd.fill[i]),
            .way_sel_inval_i (array_cmd.inval[i]),
            .fill_line_i     (refill_line),
            .hit_o           (way_hit[i]),
            .valid_o         (way_valid[i]),
            .line_o          (way_line[i])
        );
    end

    lru_table u_lru (
        .clock       (clock),
        .reset       (reset),
        .index_i     (array_cmd.index),
        .lookup_i    (lookup),
        .way_valid_i (way_valid),
        .way_hit_i   (way_hit),
        .fill_i      (|array_cmd.fill),
        .victim_o    (victim)
    );

    refill_collector u_refill (
        .clock        (clock),
        .reset        (reset),
        .start_i      (refill_start),
        .beat_valid_i (mem_ret_valid_i),
        .beat_data_i  (mem_ret_data_i),
        .last_o       (refill_last),
        .line_o       (refill_line)
    );

endmodule

//--- verification/clock_gen.sv
/*
 * Clock and reset for the cache testbench. The clock period is 8 ns
 * and reset is held for 8 cycles, then released on a falling edge.
 */
module clock_gen (
    output logic clock_o,
    output logic reset_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clock_o = 1'b0;
        forever #4 clock_o = ~clock_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (8) @(posedge clock_o);
        @(negedge clock_o);
        reset_o = 1'b0;
    end

endmodule

//--- verification/tb_icache.sv
/*
 * Testbench for the instruction cache. Directed hit, miss, uncached
 * and invalidate cases, then random operations checked against a
 * reference model. A memory responder answers line requests.
 */
module tb_icache import icache_pkg::*, icache_bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 200;
    localparam int RANDOM_OPS = 400;

    logic       clock;
    logic       reset;
    logic       fetch_valid_i;
    fetch_req_t fetch_req_i;
    logic       inval_valid_i;
    inval_req_t inval_req_i;
    logic       req_ready_o;
    logic       resp_valid_o;
    line_t      resp_line_o;
    logic       mem_req_valid_o;
    addr_t      mem_addr_o;
    logic       mem_req_ready_i;
    logic       mem_ret_valid_i;
    word_t      mem_ret_data_i;

    integer seed = 79;
    int     checks_failed = 0;

    // bit of m_lru names the next victim of its set
    tag_t           m_tag [SETS][WAYS];
    logic [WAYS-1:0] m_valid [SETS] = '{default: '0};
    logic [SETS-1:0] m_lru = '0;

    clock_gen u_clock_gen (
        .clock_o (clock),
        .reset_o (reset)
    );

    icache_top u_icache_top (
        .clock           (clock),
        .reset           (reset),
        .fetch_valid_i   (fetch_valid_i),
        .fetch_req_i     (fetch_req_i),
        .inval_valid_i   (inval_valid_i),
        .inval_req_i     (inval_req_i),
        .req_ready_o     (req_ready_o),
        .resp_valid_o    (resp_valid_o),
        .resp_line_o     (resp_line_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_addr_o      (mem_addr_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_ret_valid_i (mem_ret_valid_i),
        .mem_ret_data_i  (mem_ret_data_i)
    );

    // **************************************************
    // memory contents and address helpers
    // **************************************************
    function automatic word_t memory_word(input addr_t line_addr, input int k);
        return line_addr ^ (word_t'(k + 1) * 32'h9E37_79B9);
    endfunction

    function automatic addr_t line_base(input addr_t addr);
        return {addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    endfunction

    function automatic line_t expected_line(input addr_t addr);
        addr_t base;
        base = line_base(addr);
        return {memory_word(base, 3), memory_word(base, 2),
                memory_word(base, 1), memory_word(base, 0)};
    endfunction

    // **************************************************
    // reference model
    // **************************************************
    function automatic int find_model_way(input addr_t addr);
        index_t idx;
        tag_t   tag;
        int     found;
        idx   = addr[OFFSET_BITS +: INDEX_BITS];
        tag   = addr[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
        found = -1;
        if (m_valid[idx][0] && m_tag[idx][0] == tag) begin
            found = 0;
        end else if (m_valid[idx][1] && m_tag[idx][1] == tag) begin
            found = 1;
        end
        return found;
    endfunction

    // updates the model and returns 1 when memory must be read
    function automatic logic predict_fetch(input addr_t addr, input logic uncached);
        index_t idx;
        int     way;
        logic   victim;
        idx = addr[OFFSET_BITS +: INDEX_BITS];
        way = find_model_way(addr);
        if (uncached) begin
            return 1'b1;
        end
        if (way >= 0) begin
            m_lru[idx] = (way == 0);
            return 1'b0;
        end
        if (!m_valid[idx][0]) begin
            victim = 1'b0;
        end else if (!m_valid[idx][1]) begin
            victim = 1'b1;
        end else begin
            victim = m_lru[idx];
        end
        m_tag[idx][victim]   = addr[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
        m_valid[idx][victim] = 1'b1;
        m_lru[idx]           = !victim;
        return 1'b1;
    endfunction

    // **************************************************
    // checks
    // **************************************************
    task automatic abort_run(input string msg);
        checks_failed++;
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_line(input line_t got, input line_t exp, input addr_t addr);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0d ns: line for %h is %h, expected %h",
                                $time, addr, got, exp));
        end
    endtask

    task automatic check_mem_addr(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0d ns: memory request address %h, expected %h",
                                $time, got, exp));
        end
    endtask

    task automatic check_miss(input logic got, input logic exp, input addr_t addr);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0d ns: fetch of %h memory request %b, expected %b",
                                $time, addr, got, exp));
        end
    endtask

    // **************************************************
    // request tasks
    // **************************************************
    task automatic wait_for_ready(input string what);
        int count;
        count = 0;
        while (!req_ready_o) begin
            @(negedge clock);
            count++;
            if (count > WAIT_LIMIT) begin
                abort_run($sformatf("timeout: the cache never became ready for %s", what));
            end
        end
    endtask

    task automatic fetch_and_check(input addr_t addr, input logic uncached,
                                   output logic missed);
        logic  got_resp;
        addr_t req_addr;
        line_t got_line;
        int    cycles;
        missed   = 1'b0;
        got_resp = 1'b0;
        req_addr = '0;
        got_line = '0;
        cycles   = 0;
        @(negedge clock);
        fetch_valid_i        = 1'b1;
        fetch_req_i.addr     = addr;
        fetch_req_i.uncached = uncached;
        wait_for_ready("a fetch");
        @(posedge clock);
        while (!got_resp) begin
            @(negedge clock);
            fetch_valid_i = 1'b0;
            @(posedge clock);
            cycles++;
            if (mem_req_valid_o && mem_req_ready_i) begin
                if (missed) begin
                    abort_run("the cache made a second memory request for one fetch");
                end
                missed   = 1'b1;
                req_addr = mem_addr_o;
            end
            if (resp_valid_o) begin
                got_resp = 1'b1;
                got_line = resp_line_o;
            end else if (cycles > WAIT_LIMIT) begin
                abort_run("timeout: no response from the cache for a fetch");
            end
        end
        check_miss(missed, predict_fetch(addr, uncached), addr);
        if (missed) begin
            check_mem_addr(req_addr, line_base(addr));
        end else if (cycles != 1) begin
            abort_run($sformatf("FAILED at %0d ns: hit on %h took %0d cycles, expected 1",
                                $time, addr, cycles));
        end
        check_line(got_line, expected_line(addr), addr);
    endtask

    task automatic invalidate_way(input index_t idx, input logic way);
        @(negedge clock);
        inval_valid_i     = 1'b1;
        inval_req_i.index = idx;
        inval_req_i.way   = way;
        wait_for_ready("an invalidate");
        @(posedge clock);
        @(negedge clock);
        inval_valid_i     = 1'b0;
        m_valid[idx][way] = 1'b0;
        if (resp_valid_o || !req_ready_o) begin
            abort_run($sformatf("FAILED at %0d ns: cache not idle one cycle after invalidate",
                                $time));
        end
    endtask

    // **************************************************
    // memory responder with random ready and beat gaps
    // **************************************************
    initial begin : memory_responder
        addr_t line_addr;
        int    beat_k;
        logic  active;
        logic  next_ready;
        logic  next_beat;
        line_addr       = '0;
        beat_k          = 0;
        active          = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_ret_valid_i = 1'b0;
        mem_ret_data_i  = '0;
        forever begin
            @(posedge clock);
            if (mem_ret_valid_i) begin
                beat_k++;
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                line_addr = mem_addr_o;
                beat_k    = 0;
                active    = 1'b1;
            end
            if (beat_k == LINE_WORDS) begin
                active = 1'b0;
            end
            next_ready = ($random(seed) & 3) != 0;
            next_beat  = active && (($random(seed) & 3) != 0);
            @(negedge clock);
            mem_req_ready_i = next_ready;
            mem_ret_valid_i = next_beat;
            mem_ret_data_i  = next_beat ? memory_word(line_addr, beat_k) : '0;
        end
    end

    // **************************************************
    // stimulus
    // **************************************************
    initial begin : stimulus
        logic        missed;
        addr_t       addr_a;
        addr_t       addr_b;
        addr_t       addr_c;
        addr_t       addr_u;
        int          way_a;
        int          count;
        int unsigned pick;
        tag_t        tag_r;
        index_t      index_r;
        logic [3:0]  offset_r;
        fetch_valid_i = 1'b0;
        fetch_req_i   = '0;
        inval_valid_i = 1'b0;
        inval_req_i   = '0;

        count = 0;
        @(negedge clock);
        while (reset) begin
            @(negedge clock);
            count++;
            if (count > WAIT_LIMIT) begin
                abort_run("timeout: reset was never released");
            end
        end
        if (!req_ready_o || resp_valid_o || mem_req_valid_o) begin
            abort_run($sformatf("FAILED at %0d ns: outputs wrong after reset", $time));
        end

        // miss then hit on one line
        addr_a = {20'h12345, 8'h21, 4'h8};
        fetch_and_check(addr_a, 1'b0, missed);
        check_miss(missed, 1'b1, addr_a);
        fetch_and_check(addr_a, 1'b0, missed);
        check_miss(missed, 1'b0, addr_a);

        // uncached never allocates
        addr_u = {20'h0BEEF, 8'h37, 4'h4};
        fetch_and_check(addr_u, 1'b1, missed);
        check_miss(missed, 1'b1, addr_u);
        fetch_and_check(addr_u, 1'b1, missed);
        check_miss(missed, 1'b1, addr_u);
        fetch_and_check(addr_u, 1'b0, missed);
        check_miss(missed, 1'b1, addr_u);
        fetch_and_check(addr_u, 1'b0, missed);
        check_miss(missed, 1'b0, addr_u);

        // A, B, A, C in one set where C replaces B
        addr_a = {20'h00A0A, 8'h42, 4'h0};
        addr_b = {20'h00B0B, 8'h42, 4'hC};
        addr_c = {20'h00C0C, 8'h42, 4'h0};
        fetch_and_check(addr_a, 1'b0, missed);
        fetch_and_check(addr_b, 1'b0, missed);
        fetch_and_check(addr_a, 1'b0, missed);
        check_miss(missed, 1'b0, addr_a);
        fetch_and_check(addr_c, 1'b0, missed);
        check_miss(missed, 1'b1, addr_c);
        fetch_and_check(addr_a, 1'b0, missed);
        check_miss(missed, 1'b0, addr_a);
        fetch_and_check(addr_b, 1'b0, missed);
        check_miss(missed, 1'b1, addr_b);

        // drop A's way while B keeps hitting
        way_a = find_model_way(addr_a);
        if (way_a < 0) begin
            abort_run("the reference model does not hold line A");
        end
        invalidate_way(8'h42, way_a[0]);
        fetch_and_check(addr_a, 1'b0, missed);
        check_miss(missed, 1'b1, addr_a);
        fetch_and_check(addr_b, 1'b0, missed);
        check_miss(missed, 1'b0, addr_b);

        // random mix over five tags and four sets
        for (int n = 0; n < RANDOM_OPS; n++) begin
            @(negedge clock);
            pick     = $unsigned($random(seed)) % 8;
            tag_r    = tag_t'(($unsigned($random(seed)) % 5) * 32'h0001_0011 + 1);
            index_r  = index_t'(($unsigned($random(seed)) % 4) * 85);
            offset_r = 4'($random(seed));
            if (pick < 5) begin
                fetch_and_check({tag_r, index_r, offset_r}, 1'b0, missed);
            end else if (pick == 5) begin
                fetch_and_check({tag_r, index_r, offset_r}, 1'b1, missed);
            end else begin
                invalidate_way(index_r, offset_r[0]);
            end
        end

        if (checks_failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- build.f
source/icache_pkg.sv
source/icache_bus_pkg.sv
source/sync_ram.sv
source/cache_way.sv
source/lru_table.sv
source/refill_collector.sv
source/icache_ctrl.sv
source/icache_top.sv
verification/clock_gen.sv
verification/tb_icache.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --timing --timescale 1ns/1ps
TOP       = tb_icache
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
